// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - files:
      - ex_pkg.sv
      - ex_ctrl.sv
      - ex_alu.sv
      - ex_csr_calc.sv
      - ex_lsu_store.sv
      - ex_stage.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_ex_stage.sv

// ==== build.f ====
ex_pkg.sv
ex_ctrl.sv
ex_alu.sv
ex_csr_calc.sv
ex_lsu_store.sv
ex_stage.sv
tb_clock_gen.sv
tb_ex_stage.sv

// ==== ex_alu.sv ====
// integer ALU with operand select and RV64 word-op truncation
`timescale 1ns/1ps

module ex_alu
  import ex_pkg::*;
(
  input  word_t     i_rs1,
  input  word_t     i_pc,
  input  word_t     i_rs2,
  input  word_t     i_imm,
  input  logic      i_src1_sel,
  input  src2_sel_t i_src2_sel,
  input  alu_op_t   i_alu_op,
  input  logic      i_word_cut,
  output word_t     o_result
);

  word_t      src1;
  word_t      src2;
  word_t      srl_src;
  word_t      sra_src;
  word_t      raw;
  logic [5:0] shamt;

  assign src1 = (i_src1_sel == SRC1_PC) ? i_pc : i_rs1;

  always_comb begin
    case (i_src2_sel)
      SRC2_RS2:  src2 = i_rs2;
      SRC2_IMM:  src2 = i_imm;
      SRC2_FOUR: src2 = {{(WORD_WD-3){1'b0}}, 3'd4};  // link address
      default:   src2 = '0;
    endcase
  end

  // word ops shift by 5 bits only
  assign shamt = i_word_cut ? {1'b0, src2[4:0]} : src2[5:0];

  // right shifts see only the low word when cut
  assign srl_src = i_word_cut ? {{HWORD_WD{1'b0}}, src1[HWORD_WD-1:0]} : src1;
  assign sra_src = i_word_cut ? {{HWORD_WD{src1[HWORD_WD-1]}}, src1[HWORD_WD-1:0]} : src1;

  always_comb begin
    case (i_alu_op)
      ALU_ADD:   raw = src1 + src2;
      ALU_SUB:   raw = src1 - src2;
      ALU_SLL:   raw = src1 << shamt;
      ALU_SLT:   raw = {{(WORD_WD-1){1'b0}}, $signed(src1) < $signed(src2)};
      ALU_SLTU:  raw = {{(WORD_WD-1){1'b0}}, src1 < src2};
      ALU_XOR:   raw = src1 ^ src2;
      ALU_SRL:   raw = srl_src >> shamt;
      ALU_SRA:   raw = word_t'($signed(sra_src) >>> shamt);
      ALU_OR:    raw = src1 | src2;
      ALU_AND:   raw = src1 & src2;
      ALU_PASS2: raw = src2;
      default:   raw = '0;
    endcase
  end

  // addw/subw/sllw/... results are sign-extended from bit 31
  assign o_result = i_word_cut ? {{HWORD_WD{raw[HWORD_WD-1]}}, raw[HWORD_WD-1:0]} : raw;

endmodule

// ==== ex_csr_calc.sv ====
// new CSR value for csrrw/csrrs/csrrc and their immediate forms
`timescale 1ns/1ps

module ex_csr_calc
  import ex_pkg::*;
(
  input  csr_op_t i_csr_op,
  input  word_t   i_csr_rdata,
  input  word_t   i_rs1,
  input  word_t   i_imm,
  output word_t   o_csr_result
);

  word_t src;
  logic  use_imm;

  assign use_imm = (i_csr_op == CSR_RWI) || (i_csr_op == CSR_RSI) || (i_csr_op == CSR_RCI);
  assign src     = use_imm ? i_imm : i_rs1;  // imm already holds zimm

  always_comb begin
    case (i_csr_op)
      CSR_RW, CSR_RWI: o_csr_result = src;
      CSR_RS, CSR_RSI: o_csr_result = i_csr_rdata | src;
      CSR_RC, CSR_RCI: o_csr_result = i_csr_rdata & ~src;
      default:         o_csr_result = i_csr_rdata;  // leave csr unchanged
    endcase
  end

endmodule

// ==== ex_ctrl.sv ====
// execute stage control: valid/allowin handshake, bundle register, strobes and bypass
`timescale 1ns/1ps

module ex_ctrl
  import ex_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset,
  input  logic      i_ds_to_es_valid,
  input  ds_to_es_t i_ds_to_es_bus,
  input  logic      i_ms_allowin,
  input  logic      i_data_sram_addr_ok,
  input  word_t     i_alu_result,
  input  word_t     i_csr_result,
  output logic      o_es_allowin,
  output logic      o_es_to_ms_valid,
  output ds_to_es_t o_bundle,
  output logic      o_data_sram_ren,
  output logic      o_data_sram_wen,
  output logic      o_es_to_ds_load,
  output bypass_t   o_es_to_ds_bypass
);

  logic      es_valid;
  logic      es_ready_go;
  logic      es_mem_inst;
  logic      gpr_fwd;
  logic      csr_fwd;
  ds_to_es_t bundle_r;

  assign es_mem_inst = bundle_r.mem_ren | bundle_r.mem_wen;

  // memory ops wait for the address handshake
  assign es_ready_go      = es_mem_inst ? i_data_sram_addr_ok : 1'b1;
  assign o_es_allowin     = !es_valid || (es_ready_go && i_ms_allowin);
  assign o_es_to_ms_valid = es_valid && es_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      es_valid <= 1'b0;
    end else if (o_es_allowin) begin
      es_valid <= i_ds_to_es_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ds_to_es_valid && o_es_allowin) begin
      bundle_r <= i_ds_to_es_bus;
    end
  end

  assign o_bundle = bundle_r;

  // read request held back while ms is stalled
  assign o_data_sram_ren = es_valid && bundle_r.mem_ren && i_ms_allowin;
  assign o_data_sram_wen = es_valid && bundle_r.mem_wen;

  assign o_es_to_ds_load = es_valid && bundle_r.load;  // load-use stall in decode

  assign gpr_fwd = es_valid && bundle_r.gpr_wen;
  assign csr_fwd = es_valid && bundle_r.csr_wen;

  assign o_es_to_ds_bypass = '{
    rd:        gpr_fwd ? bundle_r.rd : '0,
    rd_value:  gpr_fwd ? i_alu_result : '0,
    csr_addr:  csr_fwd ? bundle_r.csr_addr : '0,
    csr_value: csr_fwd ? i_csr_result : '0
  };

  // decode must never mark an op as both load and store
  a_ren_wen_excl: assert property (
    @(posedge i_clk) disable iff (i_reset)
    !(o_data_sram_ren && o_data_sram_wen)
  ) else $error("data sram read and write strobes high together");

  // held item must not change under back-pressure
  a_bundle_hold: assert property (
    @(posedge i_clk) disable iff (i_reset)
    (es_valid && !o_es_allowin) |=> $stable(bundle_r)
  ) else $error("stage bundle changed while stalled");

endmodule

// ==== ex_lsu_store.sv ====
// store byte mask and lane-aligned write data for the data memory
`timescale 1ns/1ps

module ex_lsu_store
  import ex_pkg::*;
(
  input  mem_op_t    i_mem_op,
  input  logic [2:0] i_addr_low,
  input  word_t      i_wdata,
  input  logic       i_wen,
  output wmask_t     o_wmask,
  output word_t      o_wdata
);

  wmask_t     base_mask;
  logic [2:0] align_bits;  // address bits that must be zero

  always_comb begin
    case (i_mem_op[1:0])
      MEM_SZ_B: begin
        base_mask  = 8'h01;
        align_bits = 3'b000;
      end
      MEM_SZ_H: begin
        base_mask  = 8'h03;
        align_bits = 3'b001;
      end
      MEM_SZ_W: begin
        base_mask  = 8'h0f;
        align_bits = 3'b011;
      end
      default: begin  // double
        base_mask  = 8'hff;
        align_bits = 3'b111;
      end
    endcase
  end

  assign o_wmask = base_mask << i_addr_low;
  assign o_wdata = i_wdata << {i_addr_low, 3'b000};  // byte lanes

  // misaligned stores are trapped before execute
  a_store_aligned: assert final (!i_wen || ((i_addr_low & align_bits) == 3'b000))
    else $error("misaligned store, size %0d addr low %0d", i_mem_op[1:0], i_addr_low);

endmodule

// ==== ex_pkg.sv ====
// execute stage package: widths, vector types, op codes and stage bundles
package ex_pkg;

  localparam int WORD_WD       = 64;
  localparam int HWORD_WD      = 32;  // rv64 "word" ops
  localparam int GPR_ADDR_WD   = 5;
  localparam int CSR_ADDR_WD   = 12;
  localparam int SRAM_ADDR_WD  = 32;
  localparam int SRAM_WMASK_WD = 8;

  typedef logic [WORD_WD-1:0]       word_t;
  typedef logic [GPR_ADDR_WD-1:0]   gpr_addr_t;
  typedef logic [CSR_ADDR_WD-1:0]   csr_addr_t;
  typedef logic [SRAM_ADDR_WD-1:0]  sram_addr_t;
  typedef logic [SRAM_WMASK_WD-1:0] wmask_t;
  typedef logic [3:0]               alu_op_t;
  typedef logic [1:0]               src2_sel_t;
  typedef logic [2:0]               csr_op_t;
  typedef logic [2:0]               mem_op_t;

  localparam alu_op_t ALU_ADD   = 4'd0;
  localparam alu_op_t ALU_SUB   = 4'd1;
  localparam alu_op_t ALU_SLL   = 4'd2;
  localparam alu_op_t ALU_SLT   = 4'd3;
  localparam alu_op_t ALU_SLTU  = 4'd4;
  localparam alu_op_t ALU_XOR   = 4'd5;
  localparam alu_op_t ALU_SRL   = 4'd6;
  localparam alu_op_t ALU_SRA   = 4'd7;
  localparam alu_op_t ALU_OR    = 4'd8;
  localparam alu_op_t ALU_AND   = 4'd9;
  localparam alu_op_t ALU_PASS2 = 4'd10;  // lui

  localparam logic SRC1_PC = 1'b1;  // 0 picks rs1

  localparam src2_sel_t SRC2_RS2  = 2'd0;
  localparam src2_sel_t SRC2_IMM  = 2'd1;
  localparam src2_sel_t SRC2_FOUR = 2'd2;

  // bit 2 marks the zimm forms
  localparam csr_op_t CSR_RW  = 3'b001;
  localparam csr_op_t CSR_RS  = 3'b010;
  localparam csr_op_t CSR_RC  = 3'b011;
  localparam csr_op_t CSR_RWI = 3'b101;
  localparam csr_op_t CSR_RSI = 3'b110;
  localparam csr_op_t CSR_RCI = 3'b111;

  // access size, mem_op[1:0]; mem_op[2] is the unsigned-load flag
  localparam logic [1:0] MEM_SZ_B = 2'd0;
  localparam logic [1:0] MEM_SZ_H = 2'd1;
  localparam logic [1:0] MEM_SZ_W = 2'd2;
  localparam logic [1:0] MEM_SZ_D = 2'd3;

  typedef struct packed {
    logic      load;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     csr_rdata;
    word_t     imm;
    word_t     pc;
    logic      src1_sel;
    src2_sel_t src2_sel;
    logic      word_cut;
    alu_op_t   alu_op;
    gpr_addr_t rd;
    csr_addr_t csr_addr;
    logic      gpr_wen;
    logic      csr_wen;
    logic      mem_ren;
    logic      mem_wen;
    mem_op_t   mem_op;
    logic      csr_inst;   // gpr gets the old csr value
    csr_op_t   csr_op;
  } ds_to_es_t;

  typedef struct packed {
    gpr_addr_t rd;
    csr_addr_t csr_addr;
    logic      gpr_wen;
    logic      csr_wen;
    logic      mem_ren;
    logic      mem_wen;
    mem_op_t   mem_op;
    logic      csr_inst;
    word_t     csr_rdata;
    word_t     alu_result;
    word_t     csr_result;
  } es_to_ms_t;

  typedef struct packed {
    gpr_addr_t rd;
    word_t     rd_value;
    csr_addr_t csr_addr;
    word_t     csr_value;
  } bypass_t;

endpackage

// ==== ex_stage.sv ====
// execute stage top: handshake control, ALU, CSR calc and store path
`timescale 1ns/1ps

module ex_stage
  import ex_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset,
  // decode side
  input  logic       i_ds_to_es_valid,
  input  ds_to_es_t  i_ds_to_es_bus,
  output logic       o_es_allowin,
  // memory stage side
  input  logic       i_ms_allowin,
  output logic       o_es_to_ms_valid,
  output es_to_ms_t  o_es_to_ms_bus,
  // data sram
  output sram_addr_t o_data_sram_addr,
  output logic       o_data_sram_ren,
  output logic       o_data_sram_wen,
  output wmask_t     o_data_sram_wmask,
  output word_t      o_data_sram_wdata,
  input  logic       i_data_sram_addr_ok,
  // back to decode
  output bypass_t    o_es_to_ds_bypass,
  output logic       o_es_to_ds_load
);

  ds_to_es_t bundle;
  word_t     alu_result;
  word_t     csr_result;

  ex_ctrl u_ctrl (
    .i_clk               (i_clk),
    .i_reset             (i_reset),
    .i_ds_to_es_valid    (i_ds_to_es_valid),
    .i_ds_to_es_bus      (i_ds_to_es_bus),
    .i_ms_allowin        (i_ms_allowin),
    .i_data_sram_addr_ok (i_data_sram_addr_ok),
    .i_alu_result        (alu_result),
    .i_csr_result        (csr_result),
    .o_es_allowin        (o_es_allowin),
    .o_es_to_ms_valid    (o_es_to_ms_valid),
    .o_bundle            (bundle),
    .o_data_sram_ren     (o_data_sram_ren),
    .o_data_sram_wen     (o_data_sram_wen),
    .o_es_to_ds_load     (o_es_to_ds_load),
    .o_es_to_ds_bypass   (o_es_to_ds_bypass)
  );

  ex_alu u_alu (
    .i_rs1      (bundle.rs1_data),
    .i_pc       (bundle.pc),
    .i_rs2      (bundle.rs2_data),
    .i_imm      (bundle.imm),
    .i_src1_sel (bundle.src1_sel),
    .i_src2_sel (bundle.src2_sel),
    .i_alu_op   (bundle.alu_op),
    .i_word_cut (bundle.word_cut),
    .o_result   (alu_result)
  );

  ex_csr_calc u_csr_calc (
    .i_csr_op     (bundle.csr_op),
    .i_csr_rdata  (bundle.csr_rdata),
    .i_rs1        (bundle.rs1_data),
    .i_imm        (bundle.imm),
    .o_csr_result (csr_result)
  );

  ex_lsu_store u_lsu_store (
    .i_mem_op   (bundle.mem_op),
    .i_addr_low (alu_result[2:0]),  // rs1 + imm
    .i_wdata    (bundle.rs2_data),
    .i_wen      (o_data_sram_wen),
    .o_wmask    (o_data_sram_wmask),
    .o_wdata    (o_data_sram_wdata)
  );

  assign o_data_sram_addr = alu_result[SRAM_ADDR_WD-1:0];

  assign o_es_to_ms_bus = '{
    rd:         bundle.rd,
    csr_addr:   bundle.csr_addr,
    gpr_wen:    bundle.gpr_wen,
    csr_wen:    bundle.csr_wen,
    mem_ren:    bundle.mem_ren,
    mem_wen:    bundle.mem_wen,
    mem_op:     bundle.mem_op,
    csr_inst:   bundle.csr_inst,
    csr_rdata:  bundle.csr_rdata,
    alu_result: alu_result,
    csr_result: csr_result
  };

endmodule

// ==== tb_clock_gen.sv ====
// testbench clock source for the execute stage, 4 ns period
`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clk
);

  initial o_clk = 1'b0;

  always #2 o_clk = ~o_clk;  // half period

endmodule

// ==== tb_ex_stage.sv ====
// testbench for the execute stage with random bundles, reference rules and checking assertions
`timescale 1ns/1ps

module tb_ex_stage
  import ex_pkg::*;
();

  localparam int NUM_BUNDLES = 300;
  localparam int MAX_CYCLES  = 3 * NUM_BUNDLES + 200;

  logic       clk;
  logic       reset;
  logic       ds_valid;
  ds_to_es_t  ds_bus;
  logic       ms_allowin;
  logic       addr_ok;
  logic       es_allowin;
  logic       ms_valid;
  es_to_ms_t  ms_bus;
  sram_addr_t sram_addr;
  logic       sram_ren;
  logic       sram_wen;
  wmask_t     sram_wmask;
  word_t      sram_wdata;
  bypass_t    bypass;
  logic       ds_load;

  integer    seed = 90;
  int        issued = 0;
  int        sent = 0;
  int        cycles = 0;
  int        value_errs = 0;
  int        other_errs = 0;
  ds_to_es_t pending[$];  // item held by the stage
  ds_to_es_t cur = '0;
  logic      cur_valid = 1'b0;
  logic      taken = 1'b0;
  logic      exp_go;
  logic      exp_allowin;
  word_t     exp_alu;
  word_t     exp_csr;
  wmask_t    exp_wmask;
  word_t     exp_wdata;
  bypass_t   exp_bypass;
  logic [88:0] exp_fields;
  logic [88:0] got_fields;
  csr_op_t   csr_ops [6] = '{CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI};

  tb_clock_gen u_clk_gen (.o_clk(clk));

  ex_stage DUT (
    .i_clk               (clk),
    .i_reset             (reset),
    .i_ds_to_es_valid    (ds_valid),
    .i_ds_to_es_bus      (ds_bus),
    .o_es_allowin        (es_allowin),
    .i_ms_allowin        (ms_allowin),
    .o_es_to_ms_valid    (ms_valid),
    .o_es_to_ms_bus      (ms_bus),
    .o_data_sram_addr    (sram_addr),
    .o_data_sram_ren     (sram_ren),
    .o_data_sram_wen     (sram_wen),
    .o_data_sram_wmask   (sram_wmask),
    .o_data_sram_wdata   (sram_wdata),
    .i_data_sram_addr_ok (addr_ok),
    .o_es_to_ds_bypass   (bypass),
    .o_es_to_ds_load     (ds_load)
  );

  function automatic word_t alu_rule(ds_to_es_t b);
    word_t              a;
    word_t              c;
    word_t              r;
    logic [5:0]         sh;
    logic signed [31:0] lo;
    a  = b.src1_sel ? b.pc : b.rs1_data;
    c  = (b.src2_sel == SRC2_RS2) ? b.rs2_data : (b.src2_sel == SRC2_IMM) ? b.imm : 64'd4;
    sh = b.word_cut ? {1'b0, c[4:0]} : c[5:0];
    lo = $signed(a[31:0]) >>> sh;  // sraw
    case (b.alu_op)
      ALU_ADD:  r = a + c;
      ALU_SUB:  r = a - c;
      ALU_SLL:  r = a << sh;
      ALU_SLT:  r = ($signed(a) < $signed(c)) ? 64'd1 : 64'd0;
      ALU_SLTU: r = (a < c) ? 64'd1 : 64'd0;
      ALU_XOR:  r = a ^ c;
      ALU_SRL:  r = b.word_cut ? word_t'(a[31:0] >> sh) : a >> sh;
      ALU_SRA:  r = b.word_cut ? {{32{lo[31]}}, lo} : word_t'($signed(a) >>> sh);
      ALU_OR:   r = a | c;
      ALU_AND:  r = a & c;
      default:  r = c;  // pass operand 2
    endcase
    return b.word_cut ? {{32{r[31]}}, r[31:0]} : r;
  endfunction

  function automatic word_t csr_rule(ds_to_es_t b);
    word_t src;
    src = (b.csr_op inside {CSR_RWI, CSR_RSI, CSR_RCI}) ? b.imm : b.rs1_data;
    case (b.csr_op)
      CSR_RS, CSR_RSI: return b.csr_rdata | src;
      CSR_RC, CSR_RCI: return b.csr_rdata & ~src;
      default:         return src;
    endcase
  endfunction

  function automatic wmask_t mask_rule(mem_op_t op, logic [2:0] low);
    int nbytes;
    nbytes = 1 << op[1:0];
    return wmask_t'(((1 << nbytes) - 1) << low);
  endfunction

  task automatic make_bundle(output ds_to_es_t b);
    int         kind;
    logic [1:0] sz;
    kind        = $unsigned($random(seed)) % 4;
    sz          = $random(seed);
    b           = '0;
    b.rs1_data  = {$random(seed), $random(seed)};
    b.rs2_data  = {$random(seed), $random(seed)};
    b.csr_rdata = {$random(seed), $random(seed)};
    b.imm       = {$random(seed), $random(seed)};
    b.pc        = {$random(seed), $random(seed)};
    b.src1_sel  = $random(seed);
    b.src2_sel  = $unsigned($random(seed)) % 3;
    b.word_cut  = $random(seed);
    b.alu_op    = $unsigned($random(seed)) % 11;
    b.rd        = $random(seed);
    b.csr_addr  = $random(seed);
    b.gpr_wen   = $random(seed);
    if (kind == 1) begin
      b.csr_inst = 1'b1;
      b.csr_wen  = 1'b1;
      b.gpr_wen  = 1'b1;
      b.csr_op   = csr_ops[$unsigned($random(seed)) % 6];
      if (b.csr_op inside {CSR_RWI, CSR_RSI, CSR_RCI}) begin
        b.imm = {59'd0, b.imm[4:0]};  // zimm
      end
    end else if (kind >= 2) begin
      // aligned load or store at rs1 + imm
      b.src1_sel      = 1'b0;
      b.src2_sel      = SRC2_IMM;
      b.alu_op        = ALU_ADD;
      b.word_cut      = 1'b0;
      b.rs1_data[2:0] = 3'd0;
      b.imm           = {56'd0, b.imm[7:0]} & ~((64'd1 << sz) - 64'd1);
      b.mem_op        = {(kind == 2) ? b.pc[0] : 1'b0, sz};
      b.load          = (kind == 2);
      b.mem_ren       = (kind == 2);
      b.mem_wen       = (kind == 3);
      b.gpr_wen       = (kind == 2);
    end
  endtask

  task automatic report_mismatch(input string sig, input logic [159:0] exp_v,
                                 input logic [159:0] got_v);
    value_errs++;
    $display("Fail t=%0t %s expected %0h got %0h", $time, sig, exp_v, got_v);
  endtask

  always_comb begin
    exp_go      = !(cur.mem_ren || cur.mem_wen) || addr_ok;
    exp_allowin = !cur_valid || (exp_go && ms_allowin);
    exp_alu     = alu_rule(cur);
    exp_csr     = csr_rule(cur);
    exp_wmask   = mask_rule(cur.mem_op, exp_alu[2:0]);
    exp_wdata   = cur.rs2_data << (8 * exp_alu[2:0]);
    exp_bypass  = '0;
    if (cur_valid && cur.gpr_wen) begin
      exp_bypass.rd       = cur.rd;
      exp_bypass.rd_value = exp_alu;
    end
    if (cur_valid && cur.csr_wen) begin
      exp_bypass.csr_addr  = cur.csr_addr;
      exp_bypass.csr_value = exp_csr;
    end
  end

  // control fields and csr read data carried on to the memory stage
  assign exp_fields = {cur.rd, cur.csr_addr, cur.gpr_wen, cur.csr_wen, cur.mem_ren,
                       cur.mem_wen, cur.mem_op, cur.csr_inst, cur.csr_rdata};
  assign got_fields = {ms_bus.rd, ms_bus.csr_addr, ms_bus.gpr_wen, ms_bus.csr_wen, ms_bus.mem_ren,
                       ms_bus.mem_wen, ms_bus.mem_op, ms_bus.csr_inst, ms_bus.csr_rdata};

  // reference copy of the stage contents
  always @(posedge clk) begin
    if (reset) begin
      pending.delete();
      taken = 1'b0;
    end else begin
      taken = ds_valid && exp_allowin;
      if (cur_valid && exp_go && ms_allowin) begin
        void'(pending.pop_front());
      end
      if (taken) begin
        pending.push_back(ds_bus);
        sent++;
      end
    end
    cur_valid = (pending.size() != 0);
    if (cur_valid) cur = pending[0];
  end

  a_idle: assert property (@(posedge clk) disable iff (reset)
    !cur_valid |-> es_allowin && !ms_valid && !sram_ren && !sram_wen && !ds_load && bypass == '0)
    else begin
      other_errs++;
      $display("t=%0t stage is empty but handshake, strobe or bypass outputs are not idle", $time);
    end
  a_allowin: assert property (@(posedge clk) disable iff (reset) es_allowin == exp_allowin)
    else report_mismatch("o_es_allowin", $sampled(exp_allowin), $sampled(es_allowin));
  a_ms_valid: assert property (@(posedge clk) disable iff (reset) ms_valid == (cur_valid && exp_go))
    else report_mismatch("o_es_to_ms_valid", $sampled(cur_valid && exp_go), $sampled(ms_valid));
  a_alu: assert property (@(posedge clk) disable iff (reset)
    cur_valid |-> ms_bus.alu_result == exp_alu)
    else report_mismatch("alu_result", $sampled(exp_alu), $sampled(ms_bus.alu_result));
  a_csr: assert property (@(posedge clk) disable iff (reset)
    cur_valid && cur.csr_inst |-> ms_bus.csr_result == exp_csr)
    else report_mismatch("csr_result", $sampled(exp_csr), $sampled(ms_bus.csr_result));
  a_fields: assert property (@(posedge clk) disable iff (reset)
    cur_valid |-> got_fields == exp_fields)
    else report_mismatch("o_es_to_ms_bus fields", $sampled(exp_fields), $sampled(got_fields));
  a_ren: assert property (@(posedge clk) disable iff (reset)
    sram_ren == (cur_valid && cur.mem_ren && ms_allowin))
    else report_mismatch("o_data_sram_ren", $sampled(cur_valid && cur.mem_ren && ms_allowin),
                         $sampled(sram_ren));
  a_wen: assert property (@(posedge clk) disable iff (reset) sram_wen == (cur_valid && cur.mem_wen))
    else report_mismatch("o_data_sram_wen", $sampled(cur_valid && cur.mem_wen), $sampled(sram_wen));
  a_addr: assert property (@(posedge clk) disable iff (reset) cur_valid |-> sram_addr == exp_alu[31:0])
    else report_mismatch("o_data_sram_addr", $sampled(exp_alu[31:0]), $sampled(sram_addr));
  a_wmask: assert property (@(posedge clk) disable iff (reset)
    cur_valid && cur.mem_wen |-> sram_wmask == exp_wmask)
    else report_mismatch("o_data_sram_wmask", $sampled(exp_wmask), $sampled(sram_wmask));
  a_wdata: assert property (@(posedge clk) disable iff (reset)
    cur_valid && cur.mem_wen |-> sram_wdata == exp_wdata)
    else report_mismatch("o_data_sram_wdata", $sampled(exp_wdata), $sampled(sram_wdata));
  a_bypass: assert property (@(posedge clk) disable iff (reset) bypass == exp_bypass)
    else report_mismatch("o_es_to_ds_bypass", $sampled(exp_bypass), $sampled(bypass));
  a_load: assert property (@(posedge clk) disable iff (reset) ds_load == (cur_valid && cur.load))
    else report_mismatch("o_es_to_ds_load", $sampled(cur_valid && cur.load), $sampled(ds_load));
  a_hold: assert property (@(posedge clk) disable iff (reset)
    cur_valid && !ms_allowin |=> $stable(ms_bus) && $stable(sram_wdata))
    else begin
      other_errs++;
      $display("t=%0t result bus or store data changed while the memory stage stalled", $time);
    end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, %0d of %0d bundles accepted", cycles, sent, NUM_BUNDLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    reset      = 1'b1;
    ds_valid   = 1'b0;
    ds_bus     = '0;
    ms_allowin = 1'b0;
    addr_ok    = 1'b0;
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
    while (sent < NUM_BUNDLES || cur_valid) begin
      @(posedge clk);
      #1;
      if (taken || !ds_valid) begin  // decode holds a bundle until accepted
        ds_valid = (issued < NUM_BUNDLES) && ($unsigned($random(seed)) % 8 != 0);
        if (ds_valid) begin
          make_bundle(ds_bus);
          issued++;
        end
      end
      ms_allowin = ($unsigned($random(seed)) % 5) != 0;
      addr_ok    = ($unsigned($random(seed)) % 5) < 3;
    end
    repeat (3) @(posedge clk);
    $display("errors: %0d value mismatches, %0d other failures, %0d bundles in %0d cycles",
             value_errs, other_errs, sent, cycles);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
